// File: compile.f
hdl/mem_msg_pkg.sv
hdl/fetch_pkg.sv
hdl/fetch_unit.sv
hdl/inst_mem.sv
hdl/fetch_subsys.sv
testbench/tb_fetch_subsys.sv

// File: hdl/fetch_pkg.sv
/*
  Constants of the fetch stage: reset pc, instruction width and pc step.
  Imported by the fetch unit and the top level.
*/

package fetch_pkg;

  // First pc fetched after reset
  localparam logic [31:0] fetch_rst_addr = 32'h0000_0200;

  // Width of one instruction word
  localparam int inst_bits = 32;

  // Bytes between sequential instructions
  localparam int fetch_step = 4;

  // Notes
  // All instructions are one word, word aligned
  // Redirect targets are assumed word aligned too
  // No compressed encodings

endpackage

// File: hdl/fetch_subsys.sv
/*
  Fetch subsystem top level. Joins the fetch unit to the instruction ROM
  and exposes the decode channel and the redirect inputs.
*/

`timescale 1ns/100ps

module fetch_subsys
  import mem_msg_pkg::*, fetch_pkg::*;
#(
  parameter int p_opaq_bits   = 2,
  parameter int p_mem_words   = 64,
  parameter int p_queue_depth = 4
) (
  input  logic                     clk,
  input  logic                     rst,
  output logic                     inst_val,
  input  logic                     inst_rdy,
  output logic [inst_bits-1:0]     inst,
  output logic [mem_addr_bits-1:0] pc,
  input  logic                     redirect_val,
  input  logic [mem_addr_bits-1:0] redirect_target
);

  // ----------------------------------------
  // Memory channel
  // ----------------------------------------

  logic                     mem_req_val;
  logic                     mem_req_rdy;
  logic [p_opaq_bits-1:0]   mem_req_opaque;
  logic [mem_addr_bits-1:0] mem_req_addr;
  logic                     mem_resp_val;
  logic                     mem_resp_rdy;
  logic [p_opaq_bits-1:0]   mem_resp_opaque;
  logic [mem_addr_bits-1:0] mem_resp_addr;
  logic [mem_data_bits-1:0] mem_resp_data;

  // Op and len stay open, the ROM only reads whole words
  fetch_unit #(
    .p_opaq_bits (p_opaq_bits)
  ) fetch_unit_i (
    .clk             (clk),
    .rst             (rst),
    .mem_req_val     (mem_req_val),
    .mem_req_rdy     (mem_req_rdy),
    .mem_req_op      (),
    .mem_req_opaque  (mem_req_opaque),
    .mem_req_addr    (mem_req_addr),
    .mem_req_len     (),
    .mem_resp_val    (mem_resp_val),
    .mem_resp_rdy    (mem_resp_rdy),
    .mem_resp_opaque (mem_resp_opaque),
    .mem_resp_addr   (mem_resp_addr),
    .mem_resp_data   (mem_resp_data),
    .inst_val        (inst_val),
    .inst_rdy        (inst_rdy),
    .inst            (inst),
    .pc              (pc),
    .redirect_val    (redirect_val),
    .redirect_target (redirect_target)
  );

  inst_mem #(
    .p_opaq_bits   (p_opaq_bits),
    .p_mem_words   (p_mem_words),
    .p_queue_depth (p_queue_depth)
  ) inst_mem_i (
    .clk         (clk),
    .rst         (rst),
    .req_val     (mem_req_val),
    .req_rdy     (mem_req_rdy),
    .req_opaque  (mem_req_opaque),
    .req_addr    (mem_req_addr),
    .resp_val    (mem_resp_val),
    .resp_rdy    (mem_resp_rdy),
    .resp_opaque (mem_resp_opaque),
    .resp_addr   (mem_resp_addr),
    .resp_data   (mem_resp_data)
  );

endmodule

// File: hdl/fetch_unit.sv
/*
  Instruction fetch unit. Streams word reads to memory with several in
  flight, tags each with an epoch, and passes returned words to decode.
  A redirect from decode restarts fetch and squashes the old path.
*/

`timescale 1ns/100ps

module fetch_unit
  import mem_msg_pkg::*, fetch_pkg::*;
#(
  parameter int p_opaq_bits = 2
) (
  input  logic                     clk,
  input  logic                     rst,

  // Memory request
  output logic                     mem_req_val,
  input  logic                     mem_req_rdy,
  output mem_op_t                  mem_req_op,
  output logic [p_opaq_bits-1:0]   mem_req_opaque,
  output logic [mem_addr_bits-1:0] mem_req_addr,
  output logic [mem_len_bits-1:0]  mem_req_len,

  // Memory response
  input  logic                     mem_resp_val,
  output logic                     mem_resp_rdy,
  input  logic [p_opaq_bits-1:0]   mem_resp_opaque,
  input  logic [mem_addr_bits-1:0] mem_resp_addr,
  input  logic [mem_data_bits-1:0] mem_resp_data,

  // Decode channel
  output logic                     inst_val,
  input  logic                     inst_rdy,
  output logic [inst_bits-1:0]     inst,
  output logic [mem_addr_bits-1:0] pc,

  // Redirect from decode
  input  logic                     redirect_val,
  input  logic [mem_addr_bits-1:0] redirect_target
);

  // One count per tag value
  localparam logic [p_opaq_bits:0] max_in_flight = (p_opaq_bits+1)'(2 ** p_opaq_bits);

  logic                     req_xfer;
  logic                     resp_xfer;
  logic [p_opaq_bits:0]     num_in_flight;
  logic [mem_addr_bits-1:0] curr_addr;
  logic [p_opaq_bits-1:0]   epoch;
  logic                     should_drop;

  // ----------------------------------------
  // Transfers and in-flight count
  // ----------------------------------------

  assign req_xfer  = mem_req_val & mem_req_rdy;
  assign resp_xfer = mem_resp_val & mem_resp_rdy;

  // Dropped responses count as returned too
  always_ff @(posedge clk) begin
    if (rst) begin
      num_in_flight <= '0;
    end else if (req_xfer && !resp_xfer) begin
      num_in_flight <= num_in_flight + 1'b1;
    end else if (resp_xfer && !req_xfer) begin
      num_in_flight <= num_in_flight - 1'b1;
    end
  end

  // ----------------------------------------
  // Fetch address and epoch
  // ----------------------------------------

  // Redirect wins over the sequential step
  always_ff @(posedge clk) begin
    if (rst) begin
      curr_addr <= fetch_rst_addr;
    end else if (redirect_val) begin
      curr_addr <= redirect_target;
    end else if (req_xfer) begin
      curr_addr <= curr_addr + mem_addr_bits'(fetch_step);
    end
  end

  // New path, new tag
  // A request sent on the redirect edge still carries the old tag
  always_ff @(posedge clk) begin
    if (rst) begin
      epoch <= '0;
    end else if (redirect_val) begin
      epoch <= epoch + 1'b1;
    end
  end

  // ----------------------------------------
  // Request side
  // ----------------------------------------

  // Keep asking while a tag slot is free
  assign mem_req_val    = (num_in_flight < max_in_flight);
  assign mem_req_op     = mem_op_read;
  assign mem_req_opaque = epoch;
  assign mem_req_addr   = curr_addr;
  // Full word
  assign mem_req_len    = '0;

  // ----------------------------------------
  // Response side
  // ----------------------------------------

  // Tag from an older path, never shown to decode
  assign should_drop = (mem_resp_opaque != epoch);

  // Stale words are swallowed at once
  assign mem_resp_rdy = inst_rdy | should_drop;
  assign inst_val     = mem_resp_val & !should_drop;

  // Word and its address go straight through
  assign inst = mem_resp_data;
  assign pc   = mem_resp_addr;

endmodule

// File: hdl/inst_mem.sv
/*
  Instruction ROM with a two-stage read pipeline and a response queue.
  Loaded from a hex image at start-up. Request acceptance reserves queue
  space so a stalled response side never loses a word.
*/

`timescale 1ns/100ps

module inst_mem
  import mem_msg_pkg::*;
#(
  parameter int p_opaq_bits   = 2,
  parameter int p_mem_words   = 64,
  parameter int p_queue_depth = 4
) (
  input  logic                     clk,
  input  logic                     rst,

  input  logic                     req_val,
  output logic                     req_rdy,
  input  logic [p_opaq_bits-1:0]   req_opaque,
  input  logic [mem_addr_bits-1:0] req_addr,

  output logic                     resp_val,
  input  logic                     resp_rdy,
  output logic [p_opaq_bits-1:0]   resp_opaque,
  output logic [mem_addr_bits-1:0] resp_addr,
  output logic [mem_data_bits-1:0] resp_data
);

  localparam int idx_bits = (p_mem_words > 1) ? $clog2(p_mem_words) : 1;
  localparam int ptr_bits = (p_queue_depth > 1) ? $clog2(p_queue_depth) : 1;
  localparam int cnt_bits = $clog2(p_queue_depth + 1);

  logic [mem_data_bits-1:0] rom [p_mem_words];

  initial begin
    $readmemh("inst_mem.hex", rom);
  end

  logic                     req_xfer;
  logic                     deq;
  logic                     s1_val;
  logic [p_opaq_bits-1:0]   s1_opaque;
  logic [mem_addr_bits-1:0] s1_addr;
  logic [idx_bits-1:0]      s1_idx;
  logic                     s2_val;
  logic [p_opaq_bits-1:0]   s2_opaque;
  logic [mem_addr_bits-1:0] s2_addr;
  logic [mem_data_bits-1:0] s2_data;
  logic [p_opaq_bits-1:0]   q_opaque [p_queue_depth];
  logic [mem_addr_bits-1:0] q_addr [p_queue_depth];
  logic [mem_data_bits-1:0] q_data [p_queue_depth];
  logic [ptr_bits-1:0]      wr_ptr;
  logic [ptr_bits-1:0]      rd_ptr;
  logic [cnt_bits-1:0]      count;
  logic [cnt_bits-1:0]      count_next;
  logic [cnt_bits:0]        total_next;

  assign req_xfer = req_val & req_rdy;
  assign deq      = resp_val & resp_rdy;

  // ----------------------------------------
  // Read pipeline
  // ----------------------------------------

  // Word index wraps over the image
  assign s1_idx = idx_bits'((s1_addr >> 2) % p_mem_words);

  // Stage 1 latches the request, stage 2 the ROM word
  always_ff @(posedge clk) begin
    if (rst) begin
      s1_val <= 1'b0;
      s2_val <= 1'b0;
    end else begin
      s1_val <= req_xfer;
      s2_val <= s1_val;
    end
  end

  always_ff @(posedge clk) begin
    s1_opaque <= req_opaque;
    s1_addr   <= req_addr;
    s2_opaque <= s1_opaque;
    s2_addr   <= s1_addr;
    s2_data   <= rom[s1_idx];
  end

  // ----------------------------------------
  // Response queue
  // ----------------------------------------

  // Stage 2 always has room, reserved at accept time
  always_ff @(posedge clk) begin
    if (s2_val) begin
      q_opaque[wr_ptr] <= s2_opaque;
      q_addr[wr_ptr]   <= s2_addr;
      q_data[wr_ptr]   <= s2_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (s2_val) begin
        wr_ptr <= (wr_ptr == ptr_bits'(p_queue_depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (deq) begin
        rd_ptr <= (rd_ptr == ptr_bits'(p_queue_depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      count <= count_next;
    end
  end

  always_comb begin
    count_next = count;
    if (s2_val && !deq) begin
      count_next = count + 1'b1;
    end else if (deq && !s2_val) begin
      count_next = count - 1'b1;
    end
  end

  assign resp_val    = (count != '0);
  assign resp_opaque = q_opaque[rd_ptr];
  assign resp_addr   = q_addr[rd_ptr];
  assign resp_data   = q_data[rd_ptr];

  // ----------------------------------------
  // Request admission
  // ----------------------------------------

  // Reads in flight next cycle plus queued entries
  assign total_next = {1'b0, count_next} + (cnt_bits+1)'(req_xfer) + (cnt_bits+1)'(s1_val);

  // Registered so it stays low through reset
  always_ff @(posedge clk) begin
    if (rst) begin
      req_rdy <= 1'b0;
    end else begin
      req_rdy <= (total_next < (cnt_bits+1)'(p_queue_depth));
    end
  end

endmodule

// File: hdl/mem_msg_pkg.sv
/*
  Field widths and op codes of the memory request and response messages.
  Shared by the fetch unit and the instruction memory.
*/

package mem_msg_pkg;

  // ----------------------------------------
  // Message op code
  // ----------------------------------------

  // One bit is enough for read or write
  // Fetch only ever issues reads
  typedef enum logic {
    mem_op_read  = 1'b0,
    mem_op_write = 1'b1
  } mem_op_t;

  // ----------------------------------------
  // Field widths
  // ----------------------------------------

  // Byte count of the access
  // Zero encodes a full word
  localparam int mem_len_bits = 4;

  // Byte address
  localparam int mem_addr_bits = 32;

  // Payload of a response, or of a write request
  localparam int mem_data_bits = 32;

  // ----------------------------------------
  // Handshake notes
  // ----------------------------------------

  // Request fields travel with req_val, response fields with resp_val
  // A message moves on an edge with both val and rdy high
  // The opaque field has no meaning to the memory
  // Memory copies it from request to response unchanged
  // Fetch uses it as an epoch tag to spot stale responses
  // Its width is a module parameter, not a package constant

endpackage

// File: inst_mem.hex
// One 32-bit instruction word per line, word 0 at byte address 0x200
// Upper half is 0x1000 plus the word index, lower half is the byte address
10000200
10010204
10020208
1003020c
10040210
10050214
10060218
1007021c
10080220
10090224
100a0228
100b022c
100c0230
100d0234
100e0238
100f023c
10100240
10110244
10120248
1013024c
10140250
10150254
10160258
1017025c
10180260
10190264
101a0268
101b026c
101c0270
101d0274
101e0278
101f027c
10200280
10210284
10220288
1023028c
10240290
10250294
10260298
1027029c
102802a0
102902a4
102a02a8
102b02ac
102c02b0
102d02b4
102e02b8
102f02bc
103002c0
103102c4
103202c8
103302cc
103402d0
103502d4
103602d8
103702dc
103802e0
103902e4
103a02e8
103b02ec
103c02f0
103d02f4
103e02f8
103f02fc

// File: run_sim.sh
#!/bin/sh
# Build the fetch subsystem testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f compile.f --top-module tb_fetch_subsys \
  -o sim_fetch_subsys &&
  ./obj_dir/sim_fetch_subsys > sim.log 2>&1
grep -qx "SIMULATION PASSED" sim.log && echo "Run passed, see sim.log" || {
  echo "Run failed, see sim.log"
  exit 1
}

// File: testbench/tb_fetch_subsys.sv
/*
  Testbench for the fetch subsystem. Acts as decode with random back-pressure
  and periodic redirects, and checks each delivered word against a pc model.
*/

`timescale 1ns/100ps

module tb_fetch_subsys
  import fetch_pkg::*;
();

  localparam int clk_half      = 5;
  localparam int clk_period    = 2 * clk_half;
  localparam int rst_cycles    = 16;
  localparam int run_cycles    = 2000;
  localparam int margin_cycles = 50;
  localparam int redir_every   = 40;
  localparam int stall_limit   = 20;
  localparam int mem_words     = 64;
  localparam logic [15:0] lfsr_seed = 16'd59879;

  logic        clk = 1'b0;
  logic        rst;
  logic        inst_val;
  logic        inst_rdy;
  logic [31:0] inst;
  logic [31:0] pc;
  logic        redirect_val;
  logic [31:0] redirect_target;

  // Reference image and pc model
  logic [31:0] image [mem_words];
  logic [15:0] lfsr;
  logic [31:0] exp_pc;
  logic [31:0] exp_inst;
  logic [31:0] word_off;
  logic        xfer;
  logic        first_xfer;
  logic        held;
  logic [31:0] held_inst;
  logic [31:0] held_pc;
  int          stall_cnt  = 0;
  int          xfer_cnt   = 0;
  int          rst_errs   = 0;
  int          pc_errs    = 0;
  int          data_errs  = 0;
  int          hold_errs  = 0;
  int          stall_errs = 0;

  fetch_subsys #(
    .p_opaq_bits   (2),
    .p_mem_words   (mem_words),
    .p_queue_depth (4)
  ) fetch_subsys_i (
    .clk             (clk),
    .rst             (rst),
    .inst_val        (inst_val),
    .inst_rdy        (inst_rdy),
    .inst            (inst),
    .pc              (pc),
    .redirect_val    (redirect_val),
    .redirect_target (redirect_target)
  );

  always #clk_half clk = ~clk;

  // ----------------------------------------
  // Helpers
  // ----------------------------------------

  // x^16 + x^14 + x^13 + x^11 + 1, maximal length
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int n, output logic [5:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val  = {val[4:0], lfsr[0]};
    end
  endtask

  task automatic show_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("FAILED %s expected 32'h%08h actual 32'h%08h at %0t",
             name, expected, actual, $time);
  endtask

  // ----------------------------------------
  // Stimulus, driven 1 ns after each edge
  // ----------------------------------------

  initial begin : stimulus
    logic [5:0] bits;
    int         cyc;
    int         total_errs;
    rst             = 1'b1;
    inst_rdy        = 1'b0;
    redirect_val    = 1'b0;
    redirect_target = '0;
    lfsr            = lfsr_seed;
    $readmemh("inst_mem.hex", image);
    repeat (rst_cycles) @(posedge clk);
    #1;
    rst = 1'b0;
    for (cyc = 0; cyc < run_cycles; cyc++) begin
      // Ready three times out of four
      draw_bits(2, bits);
      inst_rdy = (bits[1:0] != 2'b00);
      // One-cycle redirect somewhere inside the image
      if (cyc % redir_every == redir_every - 1) begin
        draw_bits(6, bits);
        redirect_val    = 1'b1;
        redirect_target = fetch_rst_addr + {24'b0, bits, 2'b00};
      end else begin
        redirect_val = 1'b0;
      end
      @(posedge clk);
      #1;
    end
    total_errs = rst_errs + pc_errs + data_errs + hold_errs + stall_errs;
    $display("Error counts: reset %0d, pc %0d, data %0d, hold %0d, stall %0d (%0d transfers)",
             rst_errs, pc_errs, data_errs, hold_errs, stall_errs, xfer_cnt);
    if (total_errs == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // ----------------------------------------
  // Checks, sampled mid-cycle
  // ----------------------------------------

  always @(negedge clk) begin
    // Decode transfer on the coming edge
    xfer = inst_val && inst_rdy;
    if (rst) begin
      assert (!inst_val) else begin
        rst_errs++;
        $display("inst_val went high during reset at %0t", $time);
      end
      exp_pc     = fetch_rst_addr;
      first_xfer = 1'b1;
      held       = 1'b0;
      stall_cnt  = 0;
    end else begin
      // Stalled word must not move
      if (held) begin
        assert (inst_val) else begin
          hold_errs++;
          $display("inst_val dropped while decode was stalling at %0t", $time);
        end
        assert (inst == held_inst) else begin
          hold_errs++;
          show_mismatch("hold_inst", held_inst, inst);
        end
        assert (pc == held_pc) else begin
          hold_errs++;
          show_mismatch("hold_pc", held_pc, pc);
        end
      end
      if (xfer) begin
        // Image has 64 words, so six bits of word offset
        word_off = (exp_pc - fetch_rst_addr) >> 2;
        exp_inst = image[word_off[5:0]];
        assert (pc == exp_pc) else begin
          pc_errs++;
          show_mismatch(first_xfer ? "reset_first_pc" : "seq_pc", exp_pc, pc);
        end
        assert (inst == exp_inst) else begin
          data_errs++;
          show_mismatch("inst_data", exp_inst, inst);
        end
        xfer_cnt++;
        first_xfer = 1'b0;
      end
      // Redirect wins over the step
      if (redirect_val) begin
        exp_pc     = redirect_target;
        first_xfer = 1'b0;
      end else if (xfer) begin
        exp_pc = exp_pc + 32'd4;
      end
      held      = inst_val && !inst_rdy && !redirect_val;
      held_inst = inst;
      held_pc   = pc;
      // Progress watch
      if (inst_rdy && !redirect_val && !xfer) begin
        stall_cnt++;
      end else begin
        stall_cnt = 0;
      end
      assert (stall_cnt < stall_limit) else begin
        stall_errs++;
        $display("Decode channel stalled: no transfer in %0d ready cycles at %0t",
                 stall_limit, $time);
        stall_cnt = 0;
      end
    end
  end

  // Ends a hung run
  initial begin : watchdog
    #((rst_cycles + run_cycles + margin_cycles) * clk_period);
    $display("Watchdog timeout: run did not finish in %0d cycles",
             rst_cycles + run_cycles + margin_cycles);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
